// ==== chomperVga.f ====
design/chomperPkg.sv
design/scanTimer.sv
design/pressDebouncer.sv
design/spriteMotion.sv
design/spritePatternRom.sv
design/pixelRenderer.sv
design/chomperVga.sv
verification/chomperVga_assert.sv
verification/chomperVgaTb.sv

// ==== Bender.yml ====
package:
  name: chomperVga

sources:
  - files:
      - design/chomperPkg.sv
      - design/scanTimer.sv
      - design/pressDebouncer.sv
      - design/spriteMotion.sv
      - design/spritePatternRom.sv
      - design/pixelRenderer.sv
      - design/chomperVga.sv
  - target: test
    files:
      - verification/chomperVga_assert.sv
      - verification/chomperVgaTb.sv

// ==== verification/chomperVgaTb.sv ====
`timescale 1ns/10ps

module chomperVgaTb;
  import chomperPkg::*;

  localparam int DebounceCycles = 16;
  localparam int MovePeriod     = 200;
  localparam int PressLag       = DebounceCycles + 2;    // button seen high before the pulse acts
  localparam int HoldCycles     = 30;
  localparam int TimeoutCycles  = 5 * HTotal * VTotal;    // four frames of tests plus one spare

  // right-facing art, top 16 rows, body half then jaw half per pose
  localparam logic [15:0] BodyArt [16] = '{
    16'h000F, 16'h007F, 16'h00FF, 16'h03FF, 16'h07FF, 16'h0FFF, 16'h1FFF, 16'h3FFF,
    16'h3FFF, 16'h3FFF, 16'h7FFF, 16'h7FFF, 16'h7FFF, 16'hFFFF, 16'hFFFF, 16'hFFFF
  };
  localparam logic [15:0] JawArt [3][16] = '{
    '{16'hE000, 16'hF800, 16'hFE00, 16'hFC00, 16'hFFC0, 16'hFFE0, 16'hFFC0, 16'hFF80,
      16'hFF00, 16'hFE00, 16'hFC00, 16'hF800, 16'hF000, 16'hE000, 16'hC000, 16'h8000},
    '{16'hE000, 16'hF800, 16'hFE00, 16'hFF00, 16'hFF80, 16'hFFC0, 16'hFFE0, 16'hFFF0,
      16'hFFF0, 16'hFFF8, 16'hFFE0, 16'hFFC0, 16'hFF00, 16'hF800, 16'hE000, 16'hC000},
    '{16'hE000, 16'hF800, 16'hFE00, 16'hFF00, 16'hFF80, 16'hFFC0, 16'hFFE0, 16'hFFF0,
      16'hFFF8, 16'hFFFC, 16'hFFFE, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFC0, 16'hD000}
  };
  localparam logic [2:0] GateSteps [6] = '{3'b001, 3'b010, 3'b100, 3'b011, 3'b000, 3'b110};

  logic       reset;                 // clock
  logic       clk;                   // async reset, active high
  logic [3:0] buttons;               // btn0, btn1, btn2, rotDown
  logic [2:0] colorEnable;
  logic       red, green, blue, hSync, vSync;

  // model state
  int         mH, mV, tickCnt, mGait, mX, mY, frameCnt, cycleCount, btnIdx;
  int         hold [4];
  logic       pulse [4];
  logic [1:0] mHead;
  logic       mRun, tickSeen, checkOn;
  logic [4:0] expected;              // {hSync, vSync, red, green, blue}

  chomperVga #(.DebounceCycles(DebounceCycles), .MovePeriod(MovePeriod)) u_chomperVga (
    .reset(reset), .clk(clk), .btn0(buttons[0]), .btn1(buttons[1]), .btn2(buttons[2]),
    .rotDown(buttons[3]), .colorEnable(colorEnable),
    .red(red), .green(green), .blue(blue), .hSync(hSync), .vSync(vSync)
  );

  always #10 reset = ~reset;

  // expected pins for one scan position and sprite state
  function automatic logic [4:0] expectedPins(input int h, input int v, input int sx,
                                              input int sy, input logic [1:0] hd,
                                              input int gt, input logic [2:0] ce);
    logic        lit;
    logic [31:0] art;
    int          px, py, row, col, pose;
    lit  = 1'b0;
    pose = (gt == 0) ? 0 : ((gt <= 2) ? 1 : 2);
    if (h >= HVisStart && h <= HVisEnd && v >= VVisStart && v <= VVisEnd)
    begin
      px = h - HVisStart;
      py = v - VVisStart;
      if (px >= sx && px < sx + SpriteSize && py >= sy && py < sy + SpriteSize)
      begin
        row = py - sy;
        col = px - sx;
        if (row > 15)
          row = 31 - row;              // lower half folds back
        art = {BodyArt[row], JawArt[pose][row]};
        lit = hd[0] ? art[31 - col] : art[col];   // left facing reads it mirrored
      end
    end
    return {h < HSyncStart, v < VSyncStart, lit & ce[0], lit & ce[1], lit & ce[2]};
  endfunction

  task automatic abortRun(input string why);
    $display("FAIL: see errors above");
    $fatal(1, why);
  endtask

  task automatic checkPin(input string name, input logic exp, input logic act);
    assert (act === exp)
    else
    begin
      $display("[FAIL] %s expected %h got %h (cycle %0d)", name, exp, act, cycleCount);
      abortRun("output mismatch");
    end
  endtask

  // --------------------------------------------------
  // reference model, one step per rising edge
  // --------------------------------------------------
  always @(posedge reset)
  begin
    if (clk)
    begin
      expected = 5'b11000;
      {mH, mV, tickCnt, mGait, frameCnt} = '0;
      {mRun, tickSeen} = '0;
      mHead = HeadRight;
      mX    = StartX;
      mY    = StartY;
      hold  = '{default: 0};
    end
    else
    begin
      expected = expectedPins(mH, mV, mX, mY, mHead, mGait, colorEnable);
      tickSeen = (tickCnt == MovePeriod - 1);
      tickCnt  = tickSeen ? 0 : tickCnt + 1;
      if (tickSeen)
      begin
        mGait = (mGait + 1) % GaitFrames;
        if (mRun)
        begin
          case (mHead)
            HeadRight: if (mX + SpriteSize + 1 < ScreenW) mX++;
            HeadLeft:  if (mX > 1) mX--;
            HeadUp:    if (mY > 1) mY--;
            default:   if (mY + SpriteSize + 1 < ScreenH) mY++;
          endcase
        end
      end
      for (btnIdx = 0; btnIdx < 4; btnIdx++)
      begin
        pulse[btnIdx] = buttons[btnIdx] && (hold[btnIdx] == PressLag);
        hold[btnIdx]  = buttons[btnIdx] ? hold[btnIdx] + 1 : 0;
      end
      if (pulse[0])
        mHead[0] = ~mHead[0];
      else if (pulse[1])
        mHead = ~mHead;
      else if (pulse[2])
        mHead[1] = ~mHead[1];
      if (pulse[3])
        mRun = ~mRun;
      if (mH == HTotal - 1)
      begin
        mH = 0;
        mV = (mV == VTotal - 1) ? 0 : mV + 1;
        if (mV == 0)
          frameCnt++;
      end
      else
        mH++;
    end
    checkOn = 1'b1;
  end

  // outputs are settled at the falling edge
  always @(negedge reset)
  begin
    if (checkOn)
    begin
      checkPin("hSync", expected[4], hSync);
      checkPin("vSync", expected[3], vSync);
      checkPin("red",   expected[2], red);
      checkPin("green", expected[1], green);
      checkPin("blue",  expected[0], blue);
    end
  end

  always @(posedge reset)
  begin
    cycleCount++;
    if (cycleCount >= TimeoutCycles)
    begin
      $display("timeout: tests still running after %0d cycles", cycleCount);
      abortRun("timeout");
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  task automatic waitTick();
    do @(negedge reset); while (!tickSeen);
    @(posedge reset);
  endtask

  task automatic waitFrame(input int n);
    do @(negedge reset); while (frameCnt < n);
    @(posedge reset);
  endtask

  task automatic pressButton(input int idx);
    waitTick();
    buttons[idx] <= 1'b1;
    repeat (HoldCycles) @(posedge reset);
    buttons[idx] <= 1'b0;
    waitTick();                        // next press after the next tick
  endtask

  initial
  begin
    reset       = 1'b0;
    clk         = 1'b1;
    buttons     = '0;
    colorEnable = 3'b111;
    checkOn     = 1'b0;
    cycleCount  = 0;
    repeat (3) @(posedge reset);
    clk <= 1'b0;

    waitFrame(1);                      // reset image, sprite parked
    do @(negedge reset); while (mV != VVisStart + StartY);
    @(posedge reset);
    foreach (GateSteps[i])
    begin
      colorEnable <= GateSteps[i];
      repeat (5 * HTotal + 97) @(posedge reset);   // lands mid line
    end
    colorEnable <= 3'b111;

    waitFrame(2);
    pressButton(3);                    // run right
    repeat (20) waitTick();
    pressButton(3);                    // freeze, gait keeps going
    waitFrame(frameCnt + 1);           // frozen sprite drawn at its new spot
    pressButton(3);
    pressButton(0);                    // right to left
    do @(negedge reset); while (mX != 1);
    repeat (5) waitTick();
    pressButton(1);                    // left to down
    do @(negedge reset); while (mY != ScreenH - SpriteSize - 1);
    repeat (5) waitTick();
    pressButton(2);                    // down to right
    repeat (10) waitTick();
    waitFrame(frameCnt + 1);

    if (u_chomperVga.u_spriteMotion.u_motionAssert.assertFails == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== verification/chomperVga_assert.sv ====
`timescale 1ns/10ps

module chomperMotionAssert (
  input logic                          reset,
  input logic                          clk,
  input logic                          press0,
  input logic                          press1,
  input logic                          press2,
  input logic [chomperPkg::CoordW-1:0] spriteX,
  input logic [chomperPkg::CoordW-1:0] spriteY,
  input logic [1:0]                    heading,
  input logic [2:0]                    gait
);
  import chomperPkg::*;

  int assertFails = 0;                 // failed assertion count

  // --------------------------------------------------
  // motion state invariants
  // --------------------------------------------------
  gaitRange: assert property (@(posedge reset) disable iff (clk)
    gait < 3'(GaitFrames))
    else
    begin
      $error("gait counter left 0 .. 4");
      assertFails++;
    end

  // wall clamp, x in 1 .. 767 and y in 1 .. 567
  positionRange: assert property (@(posedge reset) disable iff (clk)
    (spriteX >= CoordW'(1)) && (spriteX <= CoordW'(ScreenW - SpriteSize - 1))
    && (spriteY >= CoordW'(1)) && (spriteY <= CoordW'(ScreenH - SpriteSize - 1)))
    else
    begin
      $error("sprite position outside the clamp bounds");
      assertFails++;
    end

  headingByPress: assert property (@(posedge reset) disable iff (clk)
    (heading != $past(heading)) |-> $past(press0 || press1 || press2))
    else
    begin
      $error("heading changed without a button pulse");
      assertFails++;
    end

endmodule

bind spriteMotion chomperMotionAssert u_motionAssert (
  .reset   (reset),
  .clk     (clk),
  .press0  (press0),
  .press1  (press1),
  .press2  (press2),
  .spriteX (spriteX),
  .spriteY (spriteY),
  .heading (heading),
  .gait    (gait)
);

// ==== design/chomperVga.sv ====
`timescale 1ns/10ps

module chomperVga #(
  parameter int DebounceCycles = 196608,
  parameter int MovePeriod     = 1048576
) (
  input  logic       reset,
  input  logic       clk,
  input  logic       btn0,
  input  logic       btn1,
  input  logic       btn2,
  input  logic       rotDown,
  input  logic [2:0] colorEnable,
  output logic       red,
  output logic       green,
  output logic       blue,
  output logic       hSync,
  output logic       vSync
);
  import chomperPkg::*;

  logic [CoordW-1:0] pixX;
  logic [CoordW-1:0] pixY;
  logic              visible;
  logic              hSyncRaw;
  logic              vSyncRaw;
  logic              press0;
  logic              press1;
  logic              press2;
  logic              pressRun;
  logic [CoordW-1:0] spriteX;
  logic [CoordW-1:0] spriteY;
  logic [1:0]        heading;
  logic [2:0]        gait;

  // ------------------------------------------------
  // raster
  // ------------------------------------------------
  scanTimer u_scanTimer (
    .reset    (reset),
    .clk      (clk),
    .pixX     (pixX),
    .pixY     (pixY),
    .visible  (visible),
    .hSyncRaw (hSyncRaw),
    .vSyncRaw (vSyncRaw)
  );

  // ------------------------------------------------
  // buttons
  // ------------------------------------------------
  pressDebouncer #(.DebounceCycles(DebounceCycles)) u_debounce0 (
    .reset  (reset),
    .clk    (clk),
    .button (btn0),
    .press  (press0)
  );

  pressDebouncer #(.DebounceCycles(DebounceCycles)) u_debounce1 (
    .reset  (reset),
    .clk    (clk),
    .button (btn1),
    .press  (press1)
  );

  pressDebouncer #(.DebounceCycles(DebounceCycles)) u_debounce2 (
    .reset  (reset),
    .clk    (clk),
    .button (btn2),
    .press  (press2)
  );

  pressDebouncer #(.DebounceCycles(DebounceCycles)) u_debounceRun (
    .reset  (reset),
    .clk    (clk),
    .button (rotDown),                     // rotary push, start and stop
    .press  (pressRun)
  );

  spriteMotion #(.MovePeriod(MovePeriod)) u_spriteMotion (
    .reset    (reset),
    .clk      (clk),
    .press0   (press0),
    .press1   (press1),
    .press2   (press2),
    .pressRun (pressRun),
    .spriteX  (spriteX),
    .spriteY  (spriteY),
    .heading  (heading),
    .gait     (gait)
  );

  pixelRenderer u_pixelRenderer (
    .reset       (reset),
    .clk         (clk),
    .pixX        (pixX),
    .pixY        (pixY),
    .visible     (visible),
    .hSyncRaw    (hSyncRaw),
    .vSyncRaw    (vSyncRaw),
    .spriteX     (spriteX),
    .spriteY     (spriteY),
    .heading     (heading),
    .gait        (gait),
    .colorEnable (colorEnable),
    .red         (red),
    .green       (green),
    .blue        (blue),
    .hSync       (hSync),
    .vSync       (vSync)
  );

endmodule

// ==== design/pixelRenderer.sv ====
`timescale 1ns/10ps

module pixelRenderer (
  input  logic                          reset,
  input  logic                          clk,
  input  logic [chomperPkg::CoordW-1:0] pixX,
  input  logic [chomperPkg::CoordW-1:0] pixY,
  input  logic                          visible,
  input  logic                          hSyncRaw,
  input  logic                          vSyncRaw,
  input  logic [chomperPkg::CoordW-1:0] spriteX,
  input  logic [chomperPkg::CoordW-1:0] spriteY,
  input  logic [1:0]                    heading,
  input  logic [2:0]                    gait,
  input  logic [2:0]                    colorEnable,
  output logic                          red,
  output logic                          green,
  output logic                          blue,
  output logic                          hSync,
  output logic                          vSync
);
  import chomperPkg::*;

  logic [CoordW-1:0] rowOff;
  logic [CoordW-1:0] colOff;
  logic [4:0]        colIdx;
  logic              inSprite;
  logic              spriteBit;
  spriteRowT         patternRow;

  // offsets inside the sprite square
  assign rowOff = pixY - spriteY;
  assign colOff = pixX - spriteX;

  assign inSprite = visible
                 && (pixX >= spriteX) && (colOff < CoordW'(SpriteSize))
                 && (pixY >= spriteY) && (rowOff < CoordW'(SpriteSize));

  spritePatternRom u_spritePatternRom (
    .rowIdx    (rowOff[4:0]),
    .gait      (gait),
    .faceRight (heading[0]),               // vertical headings reuse side art
    .row       (patternRow)
  );

  // leftmost column is bit 31
  assign colIdx    = 5'd31 - colOff[4:0];
  assign spriteBit = inSprite && patternRow.word[colIdx];

  // ------------------------------------------------
  // output registers, one cycle behind the scan
  // ------------------------------------------------
  always_ff @(posedge reset or posedge clk)
  begin
    if (clk)
    begin
      red   <= 1'b0;
      green <= 1'b0;
      blue  <= 1'b0;
      hSync <= 1'b1;                       // syncs idle high
      vSync <= 1'b1;
    end
    else
    begin
      red   <= spriteBit && colorEnable[0];
      green <= spriteBit && colorEnable[1];
      blue  <= spriteBit && colorEnable[2];
      hSync <= hSyncRaw;
      vSync <= vSyncRaw;
    end
  end

endmodule

// ==== design/spritePatternRom.sv ====
`timescale 1ns/10ps

module spritePatternRom (
  input  logic [4:0]            rowIdx,
  input  logic [2:0]            gait,
  input  logic                  faceRight,
  output chomperPkg::spriteRowT row
);
  import chomperPkg::*;

  // ------------------------------------------------
  // top half of the right-facing art, rows 0 .. 15
  // ------------------------------------------------
  localparam logic [15:0] BodyRows [16] = '{
    16'h000F, 16'h007F, 16'h00FF, 16'h03FF,
    16'h07FF, 16'h0FFF, 16'h1FFF, 16'h3FFF,
    16'h3FFF, 16'h3FFF, 16'h7FFF, 16'h7FFF,
    16'h7FFF, 16'hFFFF, 16'hFFFF, 16'hFFFF
  };

  // mouth wide open
  localparam logic [15:0] Jaw0Rows [16] = '{
    16'hE000, 16'hF800, 16'hFE00, 16'hFC00,
    16'hFFC0, 16'hFFE0, 16'hFFC0, 16'hFF80,
    16'hFF00, 16'hFE00, 16'hFC00, 16'hF800,
    16'hF000, 16'hE000, 16'hC000, 16'h8000
  };

  // half open
  localparam logic [15:0] Jaw1Rows [16] = '{
    16'hE000, 16'hF800, 16'hFE00, 16'hFF00,
    16'hFF80, 16'hFFC0, 16'hFFE0, 16'hFFF0,
    16'hFFF0, 16'hFFF8, 16'hFFE0, 16'hFFC0,
    16'hFF00, 16'hF800, 16'hE000, 16'hC000
  };

  // nearly shut
  localparam logic [15:0] Jaw2Rows [16] = '{
    16'hE000, 16'hF800, 16'hFE00, 16'hFF00,
    16'hFF80, 16'hFFC0, 16'hFFE0, 16'hFFF0,
    16'hFFF8, 16'hFFFC, 16'hFFFE, 16'hFFFF,
    16'hFFFF, 16'hFFFF, 16'hFFC0, 16'hD000
  };

  logic [3:0]  foldIdx;
  logic [15:0] jawHalf;
  logic [31:0] mirrored;
  spriteRowT   rightArt;

  // rows 16 .. 31 mirror rows 15 .. 0
  assign foldIdx = rowIdx[4] ? ~rowIdx[3:0] : rowIdx[3:0];

  // pose from gait: 0 -> jaw0, 1..2 -> jaw1, 3..4 -> jaw2
  always_comb
  begin
    case (gait)
      3'd0:       jawHalf = Jaw0Rows[foldIdx];
      3'd1, 3'd2: jawHalf = Jaw1Rows[foldIdx];
      default:    jawHalf = Jaw2Rows[foldIdx];
    endcase
  end

  always_comb
  begin
    rightArt.halves.leftHalf  = BodyRows[foldIdx];   // body trails
    rightArt.halves.rightHalf = jawHalf;             // jaw leads
  end

  // left art is the bit mirror, jaw ends up on the left
  assign mirrored = {<<{rightArt.word}};

  always_comb
  begin
    row.word = faceRight ? rightArt.word : mirrored;
  end

endmodule

// ==== design/spriteMotion.sv ====
`timescale 1ns/10ps

module spriteMotion #(
  parameter int MovePeriod = 1048576
) (
  input  logic                          reset,
  input  logic                          clk,
  input  logic                          press0,
  input  logic                          press1,
  input  logic                          press2,
  input  logic                          pressRun,
  output logic [chomperPkg::CoordW-1:0] spriteX,
  output logic [chomperPkg::CoordW-1:0] spriteY,
  output logic [1:0]                    heading,
  output logic [2:0]                    gait
);
  import chomperPkg::*;

  localparam int TickW = $clog2(MovePeriod + 1);

  logic [TickW-1:0] tickCount;
  logic             moveTick;
  logic             running;

  // ------------------------------------------------
  // move tick
  // ------------------------------------------------
  assign moveTick = (tickCount == TickW'(MovePeriod - 1));

  always_ff @(posedge reset or posedge clk)
  begin
    if (clk)
      tickCount <= '0;
    else if (moveTick)
      tickCount <= '0;
    else
      tickCount <= tickCount + TickW'(1);
  end

  // gait cycles on every tick, running or not
  always_ff @(posedge reset or posedge clk)
  begin
    if (clk)
      gait <= 3'd0;
    else if (moveTick)
      gait <= (gait == 3'(GaitFrames - 1)) ? 3'd0 : gait + 3'd1;
  end

  always_ff @(posedge reset or posedge clk)
  begin
    if (clk)
      running <= 1'b0;                     // starts stopped
    else if (pressRun)
      running <= ~running;
  end

  // heading buttons, press0 has priority
  always_ff @(posedge reset or posedge clk)
  begin
    if (clk)
      heading <= HeadRight;
    else if (press0)
      heading <= {heading[1], ~heading[0]};
    else if (press1)
      heading <= ~heading;
    else if (press2)
      heading <= {~heading[1], heading[0]};
  end

  // ------------------------------------------------
  // position, one pixel per tick, held at the walls
  // ------------------------------------------------
  always_ff @(posedge reset or posedge clk)
  begin
    if (clk)
    begin
      spriteX <= CoordW'(StartX);
      spriteY <= CoordW'(StartY);
    end
    else if (moveTick && running)
    begin
      case (heading)
        HeadRight:
          if (spriteX + CoordW'(SpriteSize + 1) < CoordW'(ScreenW))
            spriteX <= spriteX + CoordW'(1);
        HeadLeft:
          if (spriteX > CoordW'(1))
            spriteX <= spriteX - CoordW'(1);
        HeadUp:
          if (spriteY > CoordW'(1))
            spriteY <= spriteY - CoordW'(1);
        HeadDown:
          if (spriteY + CoordW'(SpriteSize + 1) < CoordW'(ScreenH))
            spriteY <= spriteY + CoordW'(1);
      endcase
    end
  end

endmodule

// ==== design/pressDebouncer.sv ====
`timescale 1ns/10ps

module pressDebouncer #(
  parameter int DebounceCycles = 196608
) (
  input  logic reset,
  input  logic clk,
  input  logic button,
  output logic press
);

  localparam int CntW = $clog2(DebounceCycles + 1);

  logic            syncA;
  logic            syncB;
  logic [CntW-1:0] holdCount;

  // two-flop synchronizer
  always_ff @(posedge reset or posedge clk)
  begin
    if (clk)
    begin
      syncA <= 1'b0;
      syncB <= 1'b0;
    end
    else
    begin
      syncA <= button;
      syncB <= syncA;
    end
  end

  // hold counter, saturates at DebounceCycles
  always_ff @(posedge reset or posedge clk)
  begin
    if (clk)
      holdCount <= '0;
    else if (!syncB)
      holdCount <= '0;                     // release clears
    else if (holdCount != CntW'(DebounceCycles))
      holdCount <= holdCount + CntW'(1);
  end

  // one pulse, registered on the edge the count reaches the limit
  always_ff @(posedge reset or posedge clk)
  begin
    if (clk)
      press <= 1'b0;
    else
      press <= syncB && (holdCount == CntW'(DebounceCycles - 1));
  end

endmodule

// ==== design/scanTimer.sv ====
`timescale 1ns/10ps

module scanTimer (
  input  logic                          reset,
  input  logic                          clk,
  output logic [chomperPkg::CoordW-1:0] pixX,
  output logic [chomperPkg::CoordW-1:0] pixY,
  output logic                          visible,
  output logic                          hSyncRaw,
  output logic                          vSyncRaw
);
  import chomperPkg::*;

  logic [CoordW-1:0] hScan;
  logic [CoordW-1:0] vScan;
  logic              hVis;
  logic              vVis;
  logic              lineEnd;

  assign lineEnd = (hScan == CoordW'(HTotal - 1));

  // ------------------------------------------------
  // scan counters
  // ------------------------------------------------
  always_ff @(posedge reset or posedge clk)
  begin
    if (clk)
    begin
      hScan <= '0;
      vScan <= '0;
    end
    else if (lineEnd)
    begin
      hScan <= '0;
      if (vScan == CoordW'(VTotal - 1))
        vScan <= '0;                       // frame wrap
      else
        vScan <= vScan + CoordW'(1);
    end
    else
    begin
      hScan <= hScan + CoordW'(1);
    end
  end

  // visible window
  assign hVis    = (hScan >= CoordW'(HVisStart)) && (hScan <= CoordW'(HVisEnd));
  assign vVis    = (vScan >= CoordW'(VVisStart)) && (vScan <= CoordW'(VVisEnd));
  assign visible = hVis && vVis;

  // pixel coordinates, zero outside the window
  assign pixX = hVis ? hScan - CoordW'(HVisStart) : '0;
  assign pixY = vVis ? vScan - CoordW'(VVisStart) : '0;

  // both syncs active low up to the end of the count
  assign hSyncRaw = ~(hScan >= CoordW'(HSyncStart));
  assign vSyncRaw = ~(vScan >= CoordW'(VSyncStart));

endmodule

// ==== design/chomperPkg.sv ====
package chomperPkg;

  // ------------------------------------------------
  // raster timing, counters run 0 .. total-1
  // ------------------------------------------------
  localparam int CoordW = 11;

  localparam int HTotal     = 1040;
  localparam int HVisStart  = 104;   // first visible column
  localparam int HVisEnd    = 903;   // last visible column
  localparam int HSyncStart = 920;   // sync low to HTotal-1

  localparam int VTotal     = 666;
  localparam int VVisStart  = 23;
  localparam int VVisEnd    = 622;
  localparam int VSyncStart = 660;   // sync low to VTotal-1

  localparam int ScreenW = 800;
  localparam int ScreenH = 600;

  // ------------------------------------------------
  // sprite geometry and motion
  // ------------------------------------------------
  localparam int SpriteSize = 32;
  localparam int StartX     = 400;
  localparam int StartY     = 300;
  localparam int GaitFrames = 5;     // gait counts 0 .. 4

  localparam logic [1:0] HeadUp    = 2'b00;
  localparam logic [1:0] HeadDown  = 2'b01;
  localparam logic [1:0] HeadLeft  = 2'b10;
  localparam logic [1:0] HeadRight = 2'b11;

  // one sprite row, bit 31 is the leftmost pixel
  typedef struct packed {
    logic [15:0] leftHalf;
    logic [15:0] rightHalf;
  } spriteHalvesT;

  // halves view to assemble body and jaw, word view to index by column
  typedef union packed {
    spriteHalvesT halves;
    logic [31:0]  word;
  } spriteRowT;

endpackage
